/* bench/sfifo_clk_gen.sv */
`timescale 1ns/10ps

module sfifo_clk_gen (
    output logic rclk,
    output logic rrst
);

    // 100 ns period
    initial
    begin
        rclk = 1'b0;
        forever #50 rclk = ~rclk;
    end

    // reset over two rising edges, dropped on a falling edge
    initial
    begin
        rrst = 1'b1;
        repeat (2) @(posedge rclk);
        @(negedge rclk);
        rrst = 1'b0;
    end

endmodule

/* bench/sfifo_sva.sv */
`timescale 1ns/10ps
`include "sfifo_config.svh"

module sfifo_sva (
    input logic              rclk,
    input logic              rrst,
    input logic              full,
    input logic              empty,
    input sfifo_pkg::level_t level,
    input logic              rd_accept,
    input logic              rd_valid
);

    // *******************************************************************
    // flag and level sanity
    a_full_empty : assert property (@(posedge rclk) disable iff (rrst) !(full && empty))
        else $error("full and empty high together");

    // never more than 2**depth_width entries
    a_level_max : assert property (@(posedge rclk) disable iff (rrst)
        level <= sfifo_pkg::level_t'(2**`SFIFO_DEPTH_WIDTH))
        else $error("level above fifo depth");

    // read data valid one cycle after the accepting edge
    a_rd_valid : assert property (@(posedge rclk) disable iff (rrst)
        rd_valid == $past(rd_accept))
        else $error("rd_valid does not follow rd_accept");

endmodule

// attached at the top, where rd_valid and the accept strobe meet
bind sfifo_top sfifo_sva u_sva (
    .rclk      (rclk),
    .rrst      (rrst),
    .full      (full),
    .empty     (empty),
    .level     (level),
    .rd_accept (rd_accept),
    .rd_valid  (rd_valid)
);

/* bench/sfifo_tb.sv */
`timescale 1ns/10ps
`include "sfifo_config.svh"

module sfifo_tb;

    localparam int DEPTH        = 2**`SFIFO_DEPTH_WIDTH;
    localparam int DROP_WRITES  = 260;   // enough refusals to run drop_cnt into 255
    localparam int RAND_CYCLES  = 400;
    localparam int TOTAL_CYCLES = 2 + (DEPTH + DROP_WRITES + 4) + (DEPTH + 6) + RAND_CYCLES + 4;
    localparam int WATCHDOG_NS  = (TOTAL_CYCLES + 20) * 100;   // margin of 20 cycles

    // expected state of the fifo after one edge
    typedef struct packed {
        logic              full;
        logic              empty;
        logic              af;
        logic              ae;
        logic              valid;
        logic              ovf;
        logic              udf;
        logic              seen;    // a read happened, dout is defined
        sfifo_pkg::level_t level;
        sfifo_pkg::cnt_t   drop;
        sfifo_pkg::word_t  dout;
    } exp_t;

    logic              rclk;
    logic              rrst;
    logic              wr_en;
    logic              rd_en;
    logic              err_clr;
    sfifo_pkg::word_t  din;
    sfifo_pkg::word_t  dout;
    logic              rd_valid;
    logic              full;
    logic              empty;
    logic              almost_full;
    logic              almost_empty;
    sfifo_pkg::level_t level;
    logic              overflow;
    logic              underflow;
    sfifo_pkg::cnt_t   drop_cnt;

    sfifo_pkg::word_t  model_q[$];   // queue model of the storage
    exp_t              exp_now;
    logic [31:0]       lfsr_state;

    sfifo_clk_gen u_clk (.rclk(rclk), .rrst(rrst));

    sfifo_top dut0 (
        .rclk (rclk), .rrst (rrst), .wr_en (wr_en), .din (din),
        .rd_en (rd_en), .err_clr (err_clr), .dout (dout), .rd_valid (rd_valid),
        .full (full), .empty (empty), .almost_full (almost_full),
        .almost_empty (almost_empty), .level (level), .overflow (overflow),
        .underflow (underflow), .drop_cnt (drop_cnt)
    );

    // *******************************************************************
    // random source, fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // *******************************************************************
    // reference model
    function automatic exp_t reset_model();
        exp_t e;
        model_q.delete();
        e       = '0;
        e.empty = 1'b1;
        e.ae    = 1'b1;   // level 0 is below the low mark
        return e;
    endfunction

    function automatic exp_t step_model(input exp_t prev, input logic we, input logic re,
                                        input logic clr, input sfifo_pkg::word_t d);
        exp_t e;
        logic do_wr;
        logic do_rd;
        e     = prev;
        do_wr = we && (model_q.size() < DEPTH);   // room decided before this edge
        do_rd = re && (model_q.size() > 0);
        e.valid = do_rd;
        if (do_rd)
        begin
            e.dout = model_q.pop_front();
            e.seen = 1'b1;
        end
        if (do_wr)
            model_q.push_back(d);
        // refusals beat the clear
        if (we && !do_wr)
        begin
            e.ovf = 1'b1;
            if (e.drop != 8'hff)
                e.drop = e.drop + 8'd1;
        end
        else if (clr)
        begin
            e.ovf  = 1'b0;
            e.drop = '0;
        end
        if (re && !do_rd)
            e.udf = 1'b1;
        else if (clr)
            e.udf = 1'b0;
        e.level = sfifo_pkg::level_t'(model_q.size());
        e.full  = (model_q.size() == DEPTH);
        e.empty = (model_q.size() == 0);
        e.af    = (model_q.size() >= `SFIFO_ALMOST_FULL_NUM);
        e.ae    = (model_q.size() <= `SFIFO_ALMOST_EMPTY_NUM);
        return e;
    endfunction

    // *******************************************************************
    // compare tasks, stop at the first difference
    task automatic check_word(input string name, input sfifo_pkg::word_t ev,
                              input sfifo_pkg::word_t av);
        if (av !== ev)
        begin
            $display("MISMATCH %s expected %h actual %h", name, ev, av);
            $display("** FAIL **");
            $fatal(1, "%s differs from model", name);
        end
    endtask

    task automatic check_flag(input string name, input logic ev, input logic av);
        if (av !== ev)
        begin
            $display("MISMATCH %s expected %h actual %h", name, ev, av);
            $display("** FAIL **");
            $fatal(1, "%s differs from model", name);
        end
    endtask

    task automatic check_level(input string name, input sfifo_pkg::level_t ev,
                               input sfifo_pkg::level_t av);
        if (av !== ev)
        begin
            $display("MISMATCH %s expected %h actual %h", name, ev, av);
            $display("** FAIL **");
            $fatal(1, "%s differs from model", name);
        end
    endtask

    task automatic check_cnt(input string name, input sfifo_pkg::cnt_t ev,
                             input sfifo_pkg::cnt_t av);
        if (av !== ev)
        begin
            $display("MISMATCH %s expected %h actual %h", name, ev, av);
            $display("** FAIL **");
            $fatal(1, "%s differs from model", name);
        end
    endtask

    task automatic compare_all();
        check_flag("full", exp_now.full, full);
        check_flag("empty", exp_now.empty, empty);
        check_flag("almost_full", exp_now.af, almost_full);
        check_flag("almost_empty", exp_now.ae, almost_empty);
        check_flag("rd_valid", exp_now.valid, rd_valid);
        check_flag("overflow", exp_now.ovf, overflow);
        check_flag("underflow", exp_now.udf, underflow);
        check_level("level", exp_now.level, level);
        check_cnt("drop_cnt", exp_now.drop, drop_cnt);
        if (exp_now.seen)
            check_word("dout", exp_now.dout, dout);   // also covers hold between reads
    endtask

    // one cycle of stimulus, applied on the falling edge
    task automatic drive(input logic we, input logic re, input logic clr);
        logic [31:0] r;
        r = take_bits($bits(sfifo_pkg::word_t));
        @(negedge rclk);
        wr_en   = we;
        rd_en   = re;
        err_clr = clr;
        din     = r[$bits(sfifo_pkg::word_t)-1:0];
    endtask

    // *******************************************************************
    // model steps on the rising edge, outputs checked on the falling edge
    initial
    begin : compare
        exp_now = reset_model();
        @(negedge rrst);
        compare_all();   // reset state
        forever
        begin
            @(posedge rclk);
            exp_now = step_model(exp_now, wr_en, rd_en, err_clr, din);
            @(negedge rclk);
            compare_all();
        end
    end

    initial
    begin : stimulus
        logic [31:0] r;
        lfsr_state = 32'h68e2;
        wr_en      = 1'b0;
        rd_en      = 1'b0;
        err_clr    = 1'b0;
        din        = '0;
        @(negedge rrst);
        repeat (DEPTH) drive(1'b1, 1'b0, 1'b0);         // fill up
        repeat (DROP_WRITES) drive(1'b1, 1'b0, 1'b0);   // refused writes until drop_cnt sticks
        drive(1'b1, 1'b1, 1'b0);                        // both on full, only the read goes
        drive(1'b1, 1'b0, 1'b0);                        // top it up again
        drive(1'b1, 1'b0, 1'b1);                        // clear against a refusal
        drive(1'b0, 1'b0, 1'b1);
        repeat (DEPTH) drive(1'b0, 1'b1, 1'b0);         // drain in order
        repeat (2) drive(1'b0, 1'b1, 1'b0);             // reads from an empty fifo
        drive(1'b1, 1'b1, 1'b0);                        // both on empty, only the write goes
        drive(1'b0, 1'b1, 1'b0);
        drive(1'b0, 1'b1, 1'b1);
        drive(1'b0, 1'b0, 1'b1);
        // random mix, both strobes on one edge included
        repeat (RAND_CYCLES)
        begin
            r = take_bits(5);
            drive(r[0], r[1], &r[4:2]);   // clear about one cycle in eight
        end
        repeat (3) drive(1'b0, 1'b0, 1'b0);
        @(negedge rclk);
        #1;
        $display("** PASS **");
        $finish;
    end

    initial
    begin : watchdog
        #(WATCHDOG_NS);
        $display("timeout, test did not finish within %0d ns", WATCHDOG_NS);
        $display("** FAIL **");
        $fatal(1, "watchdog expired");
    end

endmodule

/* design/sfifo_config.svh */
`ifndef SFIFO_CONFIG_SVH
`define SFIFO_CONFIG_SVH

// storage address width, 2**4 = 16 entries
`define SFIFO_DEPTH_WIDTH 4

// width of the data field in one word
`define SFIFO_DATA_WIDTH 16

// almost flag thresholds on the water level
`define SFIFO_ALMOST_FULL_NUM 14   // set at level >= this
`define SFIFO_ALMOST_EMPTY_NUM 2   // set at level <= this

`endif

/* design/sfifo_mem.sv */
`timescale 1ns/10ps
`include "sfifo_config.svh"

module sfifo_mem #(
    parameter type payload_t = sfifo_pkg::word_t
) (
    input  logic             rclk,
    input  logic             rrst,
    input  logic             wr_accept,
    input  logic             rd_accept,
    input  sfifo_pkg::addr_t waddr,
    input  sfifo_pkg::addr_t raddr,
    input  payload_t         din,
    output payload_t         dout,
    output logic             rd_valid
);

    // *******************************************************************
    // storage array, 2**depth_width words
    payload_t mem [2**`SFIFO_DEPTH_WIDTH];

    // write port
    always_ff @(posedge rclk)
    begin
        if (wr_accept)
        begin
            mem[waddr] <= din;   // stored on the accepting edge
        end
    end

    // registered read port, holds when idle
    // waddr == raddr with both strobes high cannot happen
    // since that needs full or empty, and one side is then blocked
    always_ff @(posedge rclk)
    begin
        if (rd_accept)
        begin
            dout <= mem[raddr];
        end
    end

    // valid lines up with dout
    always_ff @(posedge rclk or posedge rrst)
    begin
        if (rrst)
        begin
            rd_valid <= 1'b0;
        end
        else
        begin
            rd_valid <= rd_accept;   // one cycle pulse per read
        end
    end

endmodule

/* design/sfifo_pkg.sv */
`include "sfifo_config.svh"

package sfifo_pkg;

    // storage index
    typedef logic [`SFIFO_DEPTH_WIDTH-1:0] addr_t;

    // pointer with extra wrap bit on top
    typedef logic [`SFIFO_DEPTH_WIDTH:0] ptr_t;

    // fill level 0..16, needs the extra bit too
    typedef logic [`SFIFO_DEPTH_WIDTH:0] level_t;

    // refused-write counter, saturates at 255
    typedef logic [7:0] cnt_t;

    // payload word of the top level
    typedef struct packed {
        logic [3:0]                   tag;    // user tag
        logic [`SFIFO_DATA_WIDTH-1:0] data;   // data field
    } word_t;

endpackage

/* design/sfifo_ptr_ctrl.sv */
`timescale 1ns/10ps
`include "sfifo_config.svh"

module sfifo_ptr_ctrl (
    input  logic              rclk,
    input  logic              rrst,
    input  logic              wr_en,
    input  logic              rd_en,
    output sfifo_pkg::addr_t  waddr,
    output sfifo_pkg::addr_t  raddr,
    output logic              wr_accept,
    output logic              rd_accept,
    output logic              wr_reject,
    output logic              rd_reject,
    output logic              full,
    output logic              empty,
    output logic              almost_full,
    output logic              almost_empty,
    output sfifo_pkg::level_t level
);

    // *******************************************************************
    // internal signals
    sfifo_pkg::ptr_t   wptr;        // current write pointer
    sfifo_pkg::ptr_t   rptr;        // current read pointer
    sfifo_pkg::ptr_t   wptr_nxt;    // write pointer after this edge
    sfifo_pkg::ptr_t   rptr_nxt;    // read pointer after this edge
    sfifo_pkg::addr_t  w_lo_nxt;    // address bits of wptr_nxt
    sfifo_pkg::addr_t  r_lo_nxt;    // address bits of rptr_nxt
    logic              w_wrap_nxt;  // wrap bit of wptr_nxt
    logic              r_wrap_nxt;  // wrap bit of rptr_nxt
    logic              full_nxt;
    logic              empty_nxt;
    sfifo_pkg::level_t level_nxt;

    // *******************************************************************
    // strobes, the only place the accept rules live
    assign wr_accept = wr_en & ~full;    // full blocks the write
    assign rd_accept = rd_en & ~empty;   // empty blocks the read, no fall-through
    assign wr_reject = wr_en & full;
    assign rd_reject = rd_en & empty;

    // storage addresses come from the current pointers
    assign waddr = wptr[`SFIFO_DEPTH_WIDTH-1:0];
    assign raddr = rptr[`SFIFO_DEPTH_WIDTH-1:0];

    // next pointers
    assign wptr_nxt = wptr + sfifo_pkg::ptr_t'(wr_accept);
    assign rptr_nxt = rptr + sfifo_pkg::ptr_t'(rd_accept);

    // split into wrap bit and address
    assign w_wrap_nxt = wptr_nxt[`SFIFO_DEPTH_WIDTH];
    assign r_wrap_nxt = rptr_nxt[`SFIFO_DEPTH_WIDTH];
    assign w_lo_nxt   = wptr_nxt[`SFIFO_DEPTH_WIDTH-1:0];
    assign r_lo_nxt   = rptr_nxt[`SFIFO_DEPTH_WIDTH-1:0];

    // full when wraps differ but addresses meet
    assign full_nxt  = (w_wrap_nxt != r_wrap_nxt) && (w_lo_nxt == r_lo_nxt);
    assign empty_nxt = (wptr_nxt == rptr_nxt);   // same lap, same address

    // water level from the next pointers
    always_comb
    begin
        case ({w_wrap_nxt, r_wrap_nxt})
            2'b01:
            begin
                // writer wrapped back to 0 first, borrow the lap
                level_nxt = {1'b1, w_lo_nxt} - sfifo_pkg::level_t'(r_lo_nxt);
            end
            2'b10:
            begin
                level_nxt = wptr_nxt - sfifo_pkg::level_t'(r_lo_nxt);   // writer one lap ahead
            end
            default:
            begin
                // same lap, plain difference of addresses
                level_nxt = sfifo_pkg::level_t'(w_lo_nxt) - sfifo_pkg::level_t'(r_lo_nxt);
            end
        endcase
    end

    // *******************************************************************
    // pointer registers
    always_ff @(posedge rclk or posedge rrst)
    begin
        if (rrst)
        begin
            wptr <= '0;
            rptr <= '0;
        end
        else
        begin
            wptr <= wptr_nxt;
            rptr <= rptr_nxt;
        end
    end

    // flags and level, registered from next pointers so no extra latency
    always_ff @(posedge rclk or posedge rrst)
    begin
        if (rrst)
        begin
            full  <= 1'b0;
            empty <= 1'b1;   // starts empty
            level <= '0;
        end
        else
        begin
            full  <= full_nxt;
            empty <= empty_nxt;
            level <= level_nxt;
        end
    end

    // almost flags straight off the level
    assign almost_full  = (level >= sfifo_pkg::level_t'(`SFIFO_ALMOST_FULL_NUM));
    assign almost_empty = (level <= sfifo_pkg::level_t'(`SFIFO_ALMOST_EMPTY_NUM));

endmodule

/* design/sfifo_status.sv */
`timescale 1ns/10ps
`include "sfifo_config.svh"

module sfifo_status (
    input  logic            rclk,
    input  logic            rrst,
    input  logic            wr_reject,
    input  logic            rd_reject,
    input  logic            err_clr,
    output logic            overflow,
    output logic            underflow,
    output sfifo_pkg::cnt_t drop_cnt
);

    // *******************************************************************
    // sticky error flags
    // each flag is set by its own refusal, which beats err_clr
    always_ff @(posedge rclk or posedge rrst)
    begin
        if (rrst)
        begin
            overflow  <= 1'b0;
            underflow <= 1'b0;
        end
        else
        begin
            if (wr_reject)
                overflow <= 1'b1;      // write while full
            else if (err_clr)
                overflow <= 1'b0;

            if (rd_reject)
                underflow <= 1'b1;     // read while empty
            else if (err_clr)
                underflow <= 1'b0;
        end
    end

    // refused-write counter
    always_ff @(posedge rclk or posedge rrst)
    begin
        if (rrst)
        begin
            drop_cnt <= '0;
        end
        else if (wr_reject)
        begin
            if (~&drop_cnt)
                drop_cnt <= drop_cnt + 8'd1;   // stops at 255
        end
        else if (err_clr)
        begin
            drop_cnt <= '0;
        end
    end

endmodule

/* design/sfifo_top.sv */
`timescale 1ns/10ps
`include "sfifo_config.svh"

module sfifo_top (
    input  logic              rclk,
    input  logic              rrst,
    input  logic              wr_en,
    input  sfifo_pkg::word_t  din,
    input  logic              rd_en,
    input  logic              err_clr,
    output sfifo_pkg::word_t  dout,
    output logic              rd_valid,
    output logic              full,
    output logic              empty,
    output logic              almost_full,
    output logic              almost_empty,
    output sfifo_pkg::level_t level,
    output logic              overflow,
    output logic              underflow,
    output sfifo_pkg::cnt_t   drop_cnt
);

    // *******************************************************************
    // stage to stage wires
    logic             wr_accept;
    logic             rd_accept;
    logic             wr_reject;
    logic             rd_reject;
    sfifo_pkg::addr_t waddr;
    sfifo_pkg::addr_t raddr;

    // pointers and flags
    sfifo_ptr_ctrl u_ptr_ctrl (
        .rclk         (rclk),
        .rrst         (rrst),
        .wr_en        (wr_en),
        .rd_en        (rd_en),
        .waddr        (waddr),
        .raddr        (raddr),
        .wr_accept    (wr_accept),
        .rd_accept    (rd_accept),
        .wr_reject    (wr_reject),
        .rd_reject    (rd_reject),
        .full         (full),
        .empty        (empty),
        .almost_full  (almost_full),
        .almost_empty (almost_empty),
        .level        (level)
    );

    // storage, carries the tagged word
    sfifo_mem #(
        .payload_t (sfifo_pkg::word_t)
    ) u_mem (
        .rclk      (rclk),
        .rrst      (rrst),
        .wr_accept (wr_accept),
        .rd_accept (rd_accept),
        .waddr     (waddr),
        .raddr     (raddr),
        .din       (din),
        .dout      (dout),
        .rd_valid  (rd_valid)
    );

    // error bookkeeping
    sfifo_status u_status (
        .rclk      (rclk),
        .rrst      (rrst),
        .wr_reject (wr_reject),
        .rd_reject (rd_reject),
        .err_clr   (err_clr),
        .overflow  (overflow),
        .underflow (underflow),
        .drop_cnt  (drop_cnt)
    );

endmodule

/* run_sim.sh */
#!/bin/sh
# build the sfifo testbench with Verilator and run it
# the run counts as failed when the log holds the fail message or lacks the pass message
rm -rf obj_dir sim.log
verilator --binary --assert --timescale 1ns/10ps -f sfifo.f --top-module sfifo_tb \
    && ./obj_dir/Vsfifo_tb > sim.log 2>&1 \
    || echo "build or simulation returned an error status"
[ -f sim.log ] && cat sim.log
grep -q '\*\* FAIL \*\*' sim.log && { echo "simulation reported failure"; exit 1; }
grep -q '\*\* PASS \*\*' sim.log || { echo "no pass message in sim.log"; exit 1; }
exit 0

/* sfifo.f */
+incdir+design
design/sfifo_pkg.sv
design/sfifo_ptr_ctrl.sv
design/sfifo_mem.sv
design/sfifo_status.sv
design/sfifo_top.sv
bench/sfifo_clk_gen.sv
bench/sfifo_sva.sv
bench/sfifo_tb.sv
